// ==== compile.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
instr_decoder.sv
imm_gen.sv
operand_select.sv
decode_stage.sv
tb_decode_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the decode-stage testbench with Verilator, runs it and checks its output

verilator --binary --timing --top-module tb_decode_stage -f compile.f -o sim_decode_stage \
    && ./obj_dir/sim_decode_stage | grep "TEST PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tb_decode_table.svh ====
// Rows of instructions, hazard controls and expected results, included in the decode testbench
`ifndef TB_DECODE_TABLE_SVH
`define TB_DECODE_TABLE_SVH

// Where an expected operand value comes from
typedef enum logic [2:0] {
    S_REG,                  // Shadow copy of the source register
    S_IMM,                  // Immediate column of the row
    S_PC,
    S_EXEC,                 // EXEC_DATA on exec_fwd_i
    S_WB                    // WB_DATA on wb_i.data
} src_t;

typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    fwd_sel_t    fwd1;
    fwd_sel_t    fwd2;
    logic        stall;
    logic        flush;
    logic        wb_we;     // Write-back of WB_DATA in the same cycle
    logic [4:0]  wb_rd;
    uop_t        uop;       // Not used on stall rows, the output holds
    instr_fmt_t  fmt;
    src_t        src1;
    src_t        src2;
    logic [31:0] imm;
} row_t;

localparam uop_t E_BUB   = '0;
localparam uop_t E_ILL   = '{1'b0, 1'b1, ALU_ADD, BR_NONE, MEM_NONE, OPND_REG, 1'b0};
localparam uop_t E_LUI   = '{1'b1, 1'b0, ALU_PASS_B, BR_NONE, MEM_NONE, OPND_IMM, 1'b1};
localparam uop_t E_AUIPC = '{1'b1, 1'b0, ALU_ADD, BR_NONE, MEM_NONE, OPND_PC_IMM, 1'b1};
localparam uop_t E_JAL   = '{1'b1, 1'b0, ALU_ADD, BR_JAL, MEM_NONE, OPND_PC_IMM, 1'b1};
localparam uop_t E_JALR  = '{1'b1, 1'b0, ALU_ADD, BR_JALR, MEM_NONE, OPND_IMM, 1'b1};
localparam uop_t E_BNE   = '{1'b1, 1'b0, ALU_ADD, BR_BNE, MEM_NONE, OPND_PC_IMM, 1'b0};
localparam uop_t E_BLT   = '{1'b1, 1'b0, ALU_ADD, BR_BLT, MEM_NONE, OPND_PC_IMM, 1'b0};
localparam uop_t E_BGEU  = '{1'b1, 1'b0, ALU_ADD, BR_BGEU, MEM_NONE, OPND_PC_IMM, 1'b0};
localparam uop_t E_BEQ   = '{1'b1, 1'b0, ALU_ADD, BR_BEQ, MEM_NONE, OPND_PC_IMM, 1'b0};
localparam uop_t E_LW    = '{1'b1, 1'b0, ALU_ADD, BR_NONE, MEM_LW, OPND_IMM, 1'b1};
localparam uop_t E_SB    = '{1'b1, 1'b0, ALU_ADD, BR_NONE, MEM_SB, OPND_IMM, 1'b0};
localparam uop_t E_ADDI  = '{1'b1, 1'b0, ALU_ADD, BR_NONE, MEM_NONE, OPND_IMM, 1'b1};
localparam uop_t E_SRAI  = '{1'b1, 1'b0, ALU_SRA, BR_NONE, MEM_NONE, OPND_IMM, 1'b1};
localparam uop_t E_SUB   = '{1'b1, 1'b0, ALU_SUB, BR_NONE, MEM_NONE, OPND_REG, 1'b1};
localparam uop_t E_ADD   = '{1'b1, 1'b0, ALU_ADD, BR_NONE, MEM_NONE, OPND_REG, 1'b1};

localparam int NUM_ROWS = 22;

// instr, pc, fwd1, fwd2, stall, flush, wb_we, wb_rd / uop, fmt, src1, src2, imm
localparam row_t ROWS [NUM_ROWS] = '{
    '{32'hABCDE2B7, 32'h000, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // LUI x5
      E_LUI, FMT_U, S_REG, S_IMM, 32'hABCDE000},
    '{32'h12345317, 32'h100, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // AUIPC x6
      E_AUIPC, FMT_U, S_PC, S_IMM, 32'h12345000},
    '{32'hFF9FF0EF, 32'h200, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // JAL x1, -8
      E_JAL, FMT_J, S_PC, S_IMM, 32'hFFFFFFF8},
    '{32'h00C18167, 32'h204, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // JALR x2, 12(x3)
      E_JALR, FMT_I, S_REG, S_IMM, 32'h0000000C},
    '{32'hFE5218E3, 32'h300, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // BNE x4, x5, -16
      E_BNE, FMT_B, S_PC, S_IMM, 32'hFFFFFFF0},
    '{32'hFFC42383, 32'h304, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // LW x7, -4(x8)
      E_LW, FMT_I, S_REG, S_IMM, 32'hFFFFFFFC},
    '{32'h7A9502A3, 32'h308, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // SB x9, 0x7A5(x10)
      E_SB, FMT_S, S_REG, S_IMM, 32'h000007A5},
    '{32'hFFF60593, 32'h30C, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b1, 5'd0,      // ADDI, x0 written
      E_ADDI, FMT_I, S_REG, S_IMM, 32'hFFFFFFFF},
    '{32'h40775693, 32'h310, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // SRAI x13, x14, 7
      E_SRAI, FMT_I, S_REG, S_IMM, 32'h00000407},
    '{32'h411807B3, 32'h314, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // SUB x15, x16, x17
      E_SUB, FMT_R, S_REG, S_REG, 32'h0},
    '{32'hFFFFAFE3, 32'h318, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // Branch, funct3 010
      E_ILL, FMT_I, S_REG, S_REG, 32'h0},
    '{32'h000000B3, 32'h31C, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,      // ADD x1, x0, x0
      E_ADD, FMT_R, S_REG, S_REG, 32'h0},
    '{32'h01498933, 32'h320, FWD_WB, FWD_NONE, 1'b0, 1'b0, 1'b1, 5'd19,       // x19 written now
      E_ADD, FMT_R, S_WB, S_REG, 32'h0},
    '{32'h00098AB3, 32'h324, FWD_NONE, FWD_EXEC, 1'b0, 1'b0, 1'b0, 5'd0,      // New x19 from file
      E_ADD, FMT_R, S_REG, S_EXEC, 32'h0},
    '{32'h0020C463, 32'h400, FWD_EXEC, FWD_WB, 1'b0, 1'b0, 1'b0, 5'd0,        // Negative vs positive
      E_BLT, FMT_B, S_PC, S_IMM, 32'h00000008},
    '{32'h0020F463, 32'h404, FWD_WB, FWD_EXEC, 1'b0, 1'b0, 1'b0, 5'd0,        // Positive vs negative
      E_BGEU, FMT_B, S_PC, S_IMM, 32'h00000008},
    '{32'h00208463, 32'h408, FWD_EXEC, FWD_EXEC, 1'b0, 1'b0, 1'b0, 5'd0,      // Equal operands
      E_BEQ, FMT_B, S_PC, S_IMM, 32'h00000008},
    '{32'h411807B3, 32'h40C, FWD_NONE, FWD_NONE, 1'b1, 1'b0, 1'b0, 5'd0,      // Stall, BEQ held
      E_BUB, FMT_I, S_REG, S_REG, 32'h0},
    '{32'hFFC42383, 32'h410, FWD_NONE, FWD_NONE, 1'b1, 1'b0, 1'b0, 5'd0,      // Second stall cycle
      E_BUB, FMT_I, S_REG, S_REG, 32'h0},
    '{32'hFFC42383, 32'h410, FWD_NONE, FWD_NONE, 1'b0, 1'b1, 1'b0, 5'd0,      // Flush to bubble
      E_BUB, FMT_I, S_REG, S_REG, 32'h0},
    '{32'h12345317, 32'h500, FWD_NONE, FWD_NONE, 1'b0, 1'b0, 1'b0, 5'd0,
      E_AUIPC, FMT_U, S_PC, S_IMM, 32'h12345000},
    '{32'hFF9FF0EF, 32'h504, FWD_NONE, FWD_NONE, 1'b1, 1'b1, 1'b0, 5'd0,      // Stall beats flush
      E_BUB, FMT_I, S_REG, S_REG, 32'h0}
};

`endif

// ==== tb_decode_stage.sv ====
// Self-checking testbench for the decode stage, applies the instruction table and checks exec_o
`timescale 1ns/1ns

module tb_decode_stage;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam logic [31:0] EXEC_DATA = 32'hFFFF_FFF0;  // Negative on purpose
    localparam logic [31:0] WB_DATA   = 32'h0000_0010;

    `include "tb_decode_table.svh"

    logic         clk_i;
    logic         rst_i;
    fetch_pkt_t   fetch_i;
    wb_pkt_t      wb_i;
    logic [31:0]  exec_fwd_i;
    hazard_ctrl_t ctrl_i;
    exec_pkt_t    exec_o;
    logic [4:0]   rs1_addr_o;
    logic [4:0]   rs2_addr_o;

    logic [31:0]  shadow [32];   // Architectural register values as the testbench expects them
    exec_pkt_t    exp_pkt;
    logic         full_check;    // Cleared after a flush, only uop and fmt are defined then
    logic [31:0]  drv_instr;
    logic [31:0]  word;
    integer       seed;

    decode_stage #(
        .NUM_REGS (32)
    ) UUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fetch_i    (fetch_i),
        .wb_i       (wb_i),
        .exec_fwd_i (exec_fwd_i),
        .ctrl_i     (ctrl_i),
        .exec_o     (exec_o),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o)
    );

    always #2 clk_i = ~clk_i;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Decode stage check failed");
    endtask

    task automatic check_uop(input string name, input uop_t exp, input uop_t act);
        if (act !== exp) begin
            $display("ERR %0t ns %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_fmt(input string name, input instr_fmt_t exp, input instr_fmt_t act);
        if (act !== exp) begin
            $display("ERR %0t ns %s expected %s got %s", $time, name, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t ns %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input br_flags_t exp, input br_flags_t act);
        if (act !== exp) begin
            $display("ERR %0t ns %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_i && n < 10) begin
            @(posedge clk_i);
            n++;
        end
        if (rst_i) begin
            $display("Reset was still asserted after 10 clock cycles");
            abort_run();
        end
    endtask

    // Source value after forwarding, as the hazard unit selects it
    function automatic logic [31:0] fwd_value(input fwd_sel_t sel, input logic [4:0] addr);
        case (sel)
            FWD_EXEC: return EXEC_DATA;
            FWD_WB:   return WB_DATA;
            default:  return shadow[addr];
        endcase
    endfunction

    function automatic logic [31:0] source_value(input src_t src, input row_t r,
                                                 input logic [4:0] addr);
        case (src)
            S_IMM:   return r.imm;
            S_PC:    return r.pc;
            S_EXEC:  return EXEC_DATA;
            S_WB:    return WB_DATA;
            default: return shadow[addr];
        endcase
    endfunction

    task automatic apply_row(input row_t r);
        fetch_i.instr   <= r.instr;
        fetch_i.pc      <= r.pc;
        fetch_i.pc_next <= r.pc + 32'd4;
        ctrl_i.stall    <= r.stall;
        ctrl_i.flush    <= r.flush;
        ctrl_i.fwd1     <= r.fwd1;
        ctrl_i.fwd2     <= r.fwd2;
        wb_i.we         <= r.wb_we;
        wb_i.rd         <= r.wb_rd;
        wb_i.data       <= WB_DATA;
        exec_fwd_i      <= EXEC_DATA;
        drv_instr = r.instr;
    endtask

    // Called at the edge that captures row r, before its write-back lands
    task automatic update_expect(input row_t r);
        logic [31:0] a;
        logic [31:0] b;
        if (!r.stall) begin
            a = fwd_value(r.fwd1, r.instr[19:15]);
            b = fwd_value(r.fwd2, r.instr[24:20]);
            exp_pkt.uop       = r.uop;
            exp_pkt.fmt       = r.fmt;
            exp_pkt.val1      = source_value(r.src1, r, r.instr[19:15]);
            exp_pkt.val2      = source_value(r.src2, r, r.instr[24:20]);
            exp_pkt.flags.lt  = $signed(a) < $signed(b);
            exp_pkt.flags.ltu = a < b;
            exp_pkt.flags.eq  = a == b;
            exp_pkt.rd        = r.instr[11:7];
            exp_pkt.pc_next   = r.pc + 32'd4;
            full_check        = !r.flush;
        end
        if (r.wb_we && r.wb_rd != 5'd0) begin
            shadow[r.wb_rd] = WB_DATA;  // x0 stays zero
        end
    endtask

    task automatic check_output();
        check_uop("exec_o.uop", exp_pkt.uop, exec_o.uop);
        check_fmt("exec_o.fmt", exp_pkt.fmt, exec_o.fmt);
        if (full_check) begin
            check_word("exec_o.val1", exp_pkt.val1, exec_o.val1);
            check_word("exec_o.val2", exp_pkt.val2, exec_o.val2);
            check_flags("exec_o.flags", exp_pkt.flags, exec_o.flags);
            check_word("exec_o.rd", {27'd0, exp_pkt.rd}, {27'd0, exec_o.rd});
            check_word("exec_o.pc_next", exp_pkt.pc_next, exec_o.pc_next);
        end
        check_word("rs1_addr_o", {27'd0, drv_instr[19:15]}, {27'd0, rs1_addr_o});
        check_word("rs2_addr_o", {27'd0, drv_instr[24:20]}, {27'd0, rs2_addr_o});
    endtask

    initial begin
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        fetch_i    = '0;
        wb_i       = '0;
        exec_fwd_i = '0;
        ctrl_i     = '{1'b1, 1'b0, FWD_NONE, FWD_NONE};  // Stall while registers are loaded
        exp_pkt    = '0;
        full_check = 1'b1;
        drv_instr  = '0;
        word       = '0;
        seed       = 32'h6e03;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end

        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        wait_reset_release();
        @(negedge clk_i);
        check_uop("exec_o.uop", '0, exec_o.uop);
        check_fmt("exec_o.fmt", FMT_I, exec_o.fmt);
        check_flags("exec_o.flags", '0, exec_o.flags);

        for (int k = 1; k < 32; k++) begin
            @(posedge clk_i);
            word = $random(seed);
            wb_i <= '{1'b1, 5'(k), word};
            shadow[k] = word;
        end

        @(posedge clk_i);
        apply_row(ROWS[0]);
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk_i);
            update_expect(ROWS[i]);
            if (i + 1 < NUM_ROWS) begin
                apply_row(ROWS[i + 1]);
            end else begin
                apply_row('0);
            end
            @(negedge clk_i);
            check_output();
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== decode_stage.sv ====
// Decode and register-read stage of the RV32I pipeline, feeding one packet per cycle to execute
`timescale 1ns/1ns

module decode_stage #(
    parameter int NUM_REGS = 32     // 16 for RV32E
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  pipe_pkg::fetch_pkt_t     fetch_i,
    input  pipe_pkg::wb_pkt_t        wb_i,
    input  logic [isa_pkg::XLEN-1:0] exec_fwd_i,
    input  pipe_pkg::hazard_ctrl_t   ctrl_i,
    output pipe_pkg::exec_pkt_t      exec_o,
    output logic [4:0]               rs1_addr_o,
    output logic [4:0]               rs2_addr_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [4:0]      rd_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] val1;
    logic [XLEN-1:0] val2;
    uop_t            uop;
    instr_fmt_t      fmt;
    br_flags_t       flags;
    exec_pkt_t       exec_d;
    exec_pkt_t       exec_q;

    // Hazard unit needs the source addresses before the packet is registered
    assign rs1_addr_o = fetch_i.instr[19:15];
    assign rs2_addr_o = fetch_i.instr[24:20];
    assign rd_addr    = fetch_i.instr[11:7];

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr_o),
        .rs2_addr_i (rs2_addr_o),
        .wb_i       (wb_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    instr_decoder u_instr_decoder (
        .instr_i (fetch_i.instr),
        .uop_o   (uop),
        .fmt_o   (fmt)
    );

    imm_gen u_imm_gen (
        .instr_i (fetch_i.instr),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    operand_select u_operand_select (
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .exec_fwd_i (exec_fwd_i),
        .wb_data_i  (wb_i.data),
        .fwd1_i     (ctrl_i.fwd1),
        .fwd2_i     (ctrl_i.fwd2),
        .opnd_sel_i (uop.opnd_sel),
        .pc_i       (fetch_i.pc),
        .imm_i      (imm),
        .val1_o     (val1),
        .val2_o     (val2),
        .flags_o    (flags)
    );

    always_comb begin
        exec_d.uop     = ctrl_i.flush ? UOP_BUBBLE : uop;  // Flushed slot becomes a bubble
        exec_d.val1    = val1;
        exec_d.val2    = val2;
        exec_d.flags   = flags;
        exec_d.fmt     = ctrl_i.flush ? FMT_I : fmt;
        exec_d.rd      = rd_addr;
        exec_d.pc_next = fetch_i.pc_next;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            exec_q.uop   <= UOP_BUBBLE;
            exec_q.flags <= '0;
            exec_q.fmt   <= FMT_I;
        end else if (!ctrl_i.stall) begin
            exec_q <= exec_d;  // Stall holds the packet and overrides flush
        end
    end

    assign exec_o = exec_q;

endmodule

// ==== operand_select.sv ====
// Resolves forwarding, swaps in PC or immediate and compares the two source values
`timescale 1ns/1ns

module operand_select (
    input  logic [isa_pkg::XLEN-1:0] rs1_data_i,
    input  logic [isa_pkg::XLEN-1:0] rs2_data_i,
    input  logic [isa_pkg::XLEN-1:0] exec_fwd_i,
    input  logic [isa_pkg::XLEN-1:0] wb_data_i,
    input  pipe_pkg::fwd_sel_t       fwd1_i,
    input  pipe_pkg::fwd_sel_t       fwd2_i,
    input  isa_pkg::opnd_sel_t       opnd_sel_i,
    input  logic [isa_pkg::XLEN-1:0] pc_i,
    input  logic [isa_pkg::XLEN-1:0] imm_i,
    output logic [isa_pkg::XLEN-1:0] val1_o,
    output logic [isa_pkg::XLEN-1:0] val2_o,
    output pipe_pkg::br_flags_t      flags_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            use_pc;
    logic            use_imm;

    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_t        sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] ex_val,
        input logic [XLEN-1:0] wb_val
    );
        case (sel)
            FWD_EXEC: return ex_val;
            FWD_WB:   return wb_val;
            default:  return reg_val;
        endcase
    endfunction

    assign src1 = fwd_mux(fwd1_i, rs1_data_i, exec_fwd_i, wb_data_i);
    assign src2 = fwd_mux(fwd2_i, rs2_data_i, exec_fwd_i, wb_data_i);

    assign use_pc  = (opnd_sel_i == OPND_PC) || (opnd_sel_i == OPND_PC_IMM);
    assign use_imm = (opnd_sel_i == OPND_IMM) || (opnd_sel_i == OPND_PC_IMM);

    assign val1_o = use_pc ? pc_i : src1;
    assign val2_o = use_imm ? imm_i : src2;

    // Branches compare rs1 and rs2 even though val1/val2 carry PC and offset
    assign flags_o.lt  = $signed(src1) < $signed(src2);
    assign flags_o.ltu = src1 < src2;
    assign flags_o.eq  = src1 == src2;

endmodule

// ==== imm_gen.sv ====
// Builds the sign-extended immediate of an RV32I word for the format chosen by the decoder
`timescale 1ns/1ns

module imm_gen (
    input  logic [31:0]              instr_i,
    input  isa_pkg::instr_fmt_t      fmt_i,
    output logic [isa_pkg::XLEN-1:0] imm_o
);
    import isa_pkg::*;

    logic sign;

    assign sign = instr_i[31];  // Sign bit sits at 31 in every format

    always_comb begin
        case (fmt_i)
            FMT_I: begin
                imm_o = {{20{sign}}, instr_i[31:20]};
            end
            FMT_S: begin
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            end
            FMT_B: begin
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            FMT_U: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            FMT_J: begin
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;  // R format
            end
        endcase
    end

endmodule

// ==== instr_decoder.sv ====
// Combinational RV32I decoder giving the micro-operation and the immediate format of a word
`timescale 1ns/1ns

module instr_decoder (
    input  logic [31:0]         instr_i,
    output isa_pkg::uop_t       uop_o,
    output isa_pkg::instr_fmt_t fmt_o
);
    import isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7_b5;      // Splits ADD/SUB and SRL/SRA
    uop_t       uop;
    instr_fmt_t fmt;

    function automatic uop_t mk_uop(
        input alu_op_t   alu,
        input br_op_t    br,
        input mem_op_t   mem,
        input opnd_sel_t sel,
        input logic      wr
    );
        uop_t u;
        u.valid     = 1'b1;
        u.illegal   = 1'b0;
        u.alu_op    = alu;
        u.br_op     = br;
        u.mem_op    = mem;
        u.opnd_sel  = sel;
        u.writes_rd = wr;
        return u;
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign f7_b5  = instr_i[30];

    always_comb begin
        uop         = UOP_BUBBLE;
        uop.illegal = 1'b1;   // Stays set unless an entry below matches
        fmt         = FMT_I;
        case (opcode)
            OPC_LUI: begin
                fmt = FMT_U;
                uop = mk_uop(ALU_PASS_B, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
            end
            OPC_AUIPC: begin
                fmt = FMT_U;
                uop = mk_uop(ALU_ADD, BR_NONE, MEM_NONE, OPND_PC_IMM, 1'b1);
            end
            OPC_JAL: begin
                fmt = FMT_J;
                uop = mk_uop(ALU_ADD, BR_JAL, MEM_NONE, OPND_PC_IMM, 1'b1);  // Target is PC+imm
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    uop = mk_uop(ALU_ADD, BR_JALR, MEM_NONE, OPND_IMM, 1'b1);  // rs1+imm
                end
            end
            OPC_BRANCH: begin
                fmt = FMT_B;
                case (funct3)
                    3'b000: uop = mk_uop(ALU_ADD, BR_BEQ, MEM_NONE, OPND_PC_IMM, 1'b0);
                    3'b001: uop = mk_uop(ALU_ADD, BR_BNE, MEM_NONE, OPND_PC_IMM, 1'b0);
                    3'b100: uop = mk_uop(ALU_ADD, BR_BLT, MEM_NONE, OPND_PC_IMM, 1'b0);
                    3'b101: uop = mk_uop(ALU_ADD, BR_BGE, MEM_NONE, OPND_PC_IMM, 1'b0);
                    3'b110: uop = mk_uop(ALU_ADD, BR_BLTU, MEM_NONE, OPND_PC_IMM, 1'b0);
                    3'b111: uop = mk_uop(ALU_ADD, BR_BGEU, MEM_NONE, OPND_PC_IMM, 1'b0);
                    default: ;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000: uop = mk_uop(ALU_ADD, BR_NONE, MEM_LB, OPND_IMM, 1'b1);
                    3'b001: uop = mk_uop(ALU_ADD, BR_NONE, MEM_LH, OPND_IMM, 1'b1);
                    3'b010: uop = mk_uop(ALU_ADD, BR_NONE, MEM_LW, OPND_IMM, 1'b1);
                    3'b100: uop = mk_uop(ALU_ADD, BR_NONE, MEM_LBU, OPND_IMM, 1'b1);
                    3'b101: uop = mk_uop(ALU_ADD, BR_NONE, MEM_LHU, OPND_IMM, 1'b1);
                    default: ;
                endcase
            end
            OPC_STORE: begin
                fmt = FMT_S;
                case (funct3)
                    3'b000: uop = mk_uop(ALU_ADD, BR_NONE, MEM_SB, OPND_IMM, 1'b0);
                    3'b001: uop = mk_uop(ALU_ADD, BR_NONE, MEM_SH, OPND_IMM, 1'b0);
                    3'b010: uop = mk_uop(ALU_ADD, BR_NONE, MEM_SW, OPND_IMM, 1'b0);
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                casez ({f7_b5, funct3})
                    4'b?000: uop = mk_uop(ALU_ADD, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
                    4'b?010: uop = mk_uop(ALU_SLT, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
                    4'b?011: uop = mk_uop(ALU_SLTU, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
                    4'b?100: uop = mk_uop(ALU_XOR, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
                    4'b?110: uop = mk_uop(ALU_OR, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
                    4'b?111: uop = mk_uop(ALU_AND, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
                    4'b0001: uop = mk_uop(ALU_SLL, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
                    4'b0101: uop = mk_uop(ALU_SRL, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
                    4'b1101: uop = mk_uop(ALU_SRA, BR_NONE, MEM_NONE, OPND_IMM, 1'b1);
                    default: ;
                endcase
            end
            OPC_OP: begin
                fmt = FMT_R;
                case ({f7_b5, funct3})
                    4'b0000: uop = mk_uop(ALU_ADD, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    4'b1000: uop = mk_uop(ALU_SUB, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    4'b0001: uop = mk_uop(ALU_SLL, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    4'b0010: uop = mk_uop(ALU_SLT, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    4'b0011: uop = mk_uop(ALU_SLTU, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    4'b0100: uop = mk_uop(ALU_XOR, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    4'b0101: uop = mk_uop(ALU_SRL, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    4'b1101: uop = mk_uop(ALU_SRA, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    4'b0110: uop = mk_uop(ALU_OR, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    4'b0111: uop = mk_uop(ALU_AND, BR_NONE, MEM_NONE, OPND_REG, 1'b1);
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign uop_o = uop;
    assign fmt_o = uop.valid ? fmt : FMT_I;  // Illegal words must not look like B or J

endmodule

// ==== reg_file.sv ====
// General-purpose registers with two combinational reads, written from the write-back stage
`timescale 1ns/1ns

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic [4:0]               rs1_addr_i,
    input  logic [4:0]               rs2_addr_i,
    input  pipe_pkg::wb_pkt_t        wb_i,
    output logic [isa_pkg::XLEN-1:0] rs1_data_o,
    output logic [isa_pkg::XLEN-1:0] rs2_data_o
);
    import isa_pkg::*;

    localparam int AW = $clog2(NUM_REGS);

    logic [XLEN-1:0] regs_q [NUM_REGS];
    logic            wr_en;

    // x0 and addresses past the implemented set behave as hard-wired zero
    function automatic logic live_reg(input logic [4:0] addr);
        return (addr != 5'd0) && (int'(addr) < NUM_REGS);
    endfunction

    assign wr_en = wb_i.we && live_reg(wb_i.rd);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                regs_q[k] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd[AW-1:0]] <= wb_i.data;  // Seen by reads next cycle
        end
    end

    assign rs1_data_o = live_reg(rs1_addr_i) ? regs_q[rs1_addr_i[AW-1:0]] : '0;
    assign rs2_data_o = live_reg(rs2_addr_i) ? regs_q[rs2_addr_i[AW-1:0]] : '0;

endmodule

// ==== pipe_pkg.sv ====
// Packets exchanged between pipeline stages and the hazard unit's forwarding codes
package pipe_pkg;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,    // Register file value
        FWD_EXEC = 2'd1,    // Result leaving execute
        FWD_WB   = 2'd2     // Value being written back
    } fwd_sel_t;

    typedef struct packed {
        logic [31:0]               instr;
        logic [isa_pkg::XLEN-1:0]  pc;
        logic [isa_pkg::XLEN-1:0]  pc_next;   // PC of the following instruction, link value
    } fetch_pkt_t;

    typedef struct packed {
        logic                      we;
        logic [4:0]                rd;
        logic [isa_pkg::XLEN-1:0]  data;
    } wb_pkt_t;

    typedef struct packed {
        logic                      stall;
        logic                      flush;
        fwd_sel_t                  fwd1;
        fwd_sel_t                  fwd2;
    } hazard_ctrl_t;

    // Relations between the two forwarded source values
    typedef struct packed {
        logic                      lt;
        logic                      ltu;
        logic                      eq;
    } br_flags_t;

    typedef struct packed {
        isa_pkg::uop_t             uop;
        logic [isa_pkg::XLEN-1:0]  val1;
        logic [isa_pkg::XLEN-1:0]  val2;
        br_flags_t                 flags;
        isa_pkg::instr_fmt_t       fmt;       // Tells execute whether a B or J target applies
        logic [4:0]                rd;
        logic [isa_pkg::XLEN-1:0]  pc_next;
    } exec_pkt_t;

endpackage

// ==== isa_pkg.sv ====
// RV32I opcodes, operation encodings and the micro-operation record, imported by decode logic
package isa_pkg;

    localparam int XLEN = 32;

    // Base opcodes, instruction bits 6:0
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } instr_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,            // Also used for address and target sums
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B          // LUI passes the immediate
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } br_op_t;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LBU,
        MEM_LHU,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_t;

    // Operand 1 takes PC for PC and PC_IMM, operand 2 the immediate for IMM and PC_IMM
    typedef enum logic [1:0] {
        OPND_REG,
        OPND_IMM,
        OPND_PC,
        OPND_PC_IMM
    } opnd_sel_t;

    typedef struct packed {
        logic      valid;
        logic      illegal;
        alu_op_t   alu_op;
        br_op_t    br_op;
        mem_op_t   mem_op;
        opnd_sel_t opnd_sel;
        logic      writes_rd;
    } uop_t;

    localparam uop_t UOP_BUBBLE = '0;  // No-op slot in the pipeline

endpackage
